// File: common/sb_config.svh
`ifndef SB_CONFIG_SVH
`define SB_CONFIG_SVH

// ----------------------------------------------------------
// scoreboard sizes
// ----------------------------------------------------------

// depth of the entry queue, must stay a power of two
`define SB_NR_ENTRIES 8

// number of entries offered to commit per cycle
`define SB_NR_COMMIT 2

// integer data path width
`define SB_XLEN 64

// architectural register address width and register count
`define SB_REG_ADDR 5
`define SB_NR_REGS 32

// width of the exception cause field
`define SB_CAUSE_W 64

`endif

// File: common/sb_instr_pkg.sv
`default_nettype none

`include "sb_config.svh"

package sb_instr_pkg;

  // ----------------------------------------------------------
  // functional units
  // ----------------------------------------------------------
  // NONE marks a register with no pending writer
  typedef enum logic [2:0] {
    NONE      = 3'd0,
    LOAD      = 3'd1,
    STORE     = 3'd2,
    ALU       = 3'd3,
    CTRL_FLOW = 3'd4,
    MULT      = 3'd5,
    CSR       = 3'd6
  } fu_t;

  // transaction id is the slot index in the entry queue
  typedef logic [$clog2(`SB_NR_ENTRIES)-1:0] trans_id_t;

  // architectural register address
  typedef logic [`SB_REG_ADDR-1:0] reg_addr_t;

  // exception raised by a functional unit
  typedef struct packed {
    logic [`SB_CAUSE_W-1:0] cause;
    logic [`SB_XLEN-1:0]    tval;
    logic                   valid;
  } exception_t;

  // ----------------------------------------------------------
  // scoreboard entry
  // ----------------------------------------------------------
  // valid means the result has been written back
  typedef struct packed {
    trans_id_t           trans_id;
    fu_t                 fu;
    reg_addr_t           rd;
    logic [`SB_XLEN-1:0] result;
    logic                valid;
    exception_t          ex;
  } sb_entry_t;

endpackage

`default_nettype wire

// File: common/sb_port_pkg.sv
`default_nettype none

`include "sb_config.svh"

package sb_port_pkg;

  // ----------------------------------------------------------
  // write-back port
  // ----------------------------------------------------------
  // one beat from a functional unit, addressed by transaction id
  typedef struct packed {
    logic                    valid;
    sb_instr_pkg::trans_id_t trans_id;
    logic [`SB_XLEN-1:0]     data;
    sb_instr_pkg::exception_t ex;
  } wb_port_t;

  // ----------------------------------------------------------
  // clobber map
  // ----------------------------------------------------------
  // pending writer unit, one slot per architectural register
  typedef sb_instr_pkg::fu_t [`SB_NR_REGS-1:0] clobber_vec_t;

endpackage

`default_nettype wire

// File: issue_queue/sb_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_config.svh"

module sb_issue_queue (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          flush_i,
  input  logic                                          flush_unissued_i,
  input  sb_instr_pkg::sb_entry_t                       decoded_instr_i,
  input  logic                                          decoded_instr_valid_i,
  input  logic                                          issue_ack_i,
  input  logic                                          unresolved_branch_i,
  input  sb_port_pkg::wb_port_t                         wb_i,
  input  logic [`SB_NR_COMMIT-1:0]                      commit_ack_i,
  output logic                                          issue_instr_valid_o,
  output logic                                          decoded_instr_ack_o,
  output sb_instr_pkg::trans_id_t                       issue_trans_id_o,
  output logic                                          sb_full_o,
  output sb_instr_pkg::sb_entry_t [`SB_NR_COMMIT-1:0]   commit_instr_o,
  output sb_instr_pkg::sb_entry_t [`SB_NR_ENTRIES-1:0]  entries_o,
  output logic [`SB_NR_ENTRIES-1:0]                     issued_o
);
  import sb_instr_pkg::*;

  localparam int unsigned IDX_W = $bits(trans_id_t);
  localparam int unsigned CNT_W = $clog2(`SB_NR_COMMIT) + 1;

  // payload of each slot, valid and ex.valid live in the flag vectors
  sb_entry_t mem_q [`SB_NR_ENTRIES];
  sb_entry_t mem_d [`SB_NR_ENTRIES];

  // per slot flags: issued, written back, exception recorded
  logic [`SB_NR_ENTRIES-1:0] issued_q, issued_d;
  logic [`SB_NR_ENTRIES-1:0] done_q, done_d;
  logic [`SB_NR_ENTRIES-1:0] exv_q, exv_d;

  trans_id_t        issue_ptr_q, issue_ptr_d;
  trans_id_t        commit_ptr_q, commit_ptr_d;
  trans_id_t        cnt_q, cnt_d;
  logic [CNT_W-1:0] num_commit;
  logic             full;
  logic             issue_en;

  // ----------------------------------------------------------
  // issue handshake
  // ----------------------------------------------------------
  // full one slot early so the count never wraps
  assign full      = (cnt_q == trans_id_t'(`SB_NR_ENTRIES - 1));
  assign sb_full_o = full;

  assign issue_instr_valid_o = decoded_instr_valid_i & ~unresolved_branch_i & ~full;
  assign decoded_instr_ack_o = issue_ack_i & ~full;
  assign issue_trans_id_o    = issue_ptr_q;

  // store only when the decoder hands over and no unissued flush
  assign issue_en = decoded_instr_valid_i & decoded_instr_ack_o & ~flush_unissued_i;

  // ----------------------------------------------------------
  // entry view for commit, clobber and forwarding
  // ----------------------------------------------------------
  always_comb begin : entry_view
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      entries_o[i]          = mem_q[i];
      entries_o[i].valid    = done_q[i];
      entries_o[i].ex.valid = exv_q[i];
    end
  end

  assign issued_o = issued_q;

  // commit ports look at the oldest slots in order
  for (genvar k = 0; k < `SB_NR_COMMIT; k++) begin : gen_commit
    trans_id_t slot;
    assign slot              = commit_ptr_q + trans_id_t'(k);
    assign commit_instr_o[k] = entries_o[slot];
  end

  // ----------------------------------------------------------
  // slot update: store, write-back, commit, flush
  // ----------------------------------------------------------
  always_comb begin : queue_update
    trans_id_t slot;
    mem_d    = mem_q;
    issued_d = issued_q;
    done_d   = done_q;
    exv_d    = exv_q;

    // new entry at the issue pointer, id replaced by the slot
    if (issue_en) begin
      mem_d[issue_ptr_q]          = decoded_instr_i;
      mem_d[issue_ptr_q].trans_id = issue_ptr_q;
      issued_d[issue_ptr_q]       = 1'b1;
      done_d[issue_ptr_q]         = decoded_instr_i.valid;
      exv_d[issue_ptr_q]          = decoded_instr_i.ex.valid;
    end

    // late write-backs after a flush hit a non-issued slot and are dropped
    if (wb_i.valid && issued_q[wb_i.trans_id]) begin
      done_d[wb_i.trans_id]       = 1'b1;
      mem_d[wb_i.trans_id].result = wb_i.data;
      if (wb_i.ex.valid) begin
        mem_d[wb_i.trans_id].ex = wb_i.ex;
        exv_d[wb_i.trans_id]    = 1'b1;
      end
    end

    // retire acknowledged slots
    for (int k = 0; k < `SB_NR_COMMIT; k++) begin
      slot = commit_ptr_q + trans_id_t'(k);
      if (commit_ack_i[k]) begin
        issued_d[slot] = 1'b0;
        done_d[slot]   = 1'b0;
      end
    end

    if (flush_i) begin
      issued_d = '0;
      done_d   = '0;
      exv_d    = '0;
    end
  end

  // ----------------------------------------------------------
  // pointers and count
  // ----------------------------------------------------------
  always_comb begin : commit_count
    num_commit = '0;
    for (int k = 0; k < `SB_NR_COMMIT; k++) begin
      num_commit = num_commit + CNT_W'(commit_ack_i[k]);
    end
  end

  assign cnt_d        = flush_i ? '0 : cnt_q - trans_id_t'(num_commit) + trans_id_t'(issue_en);
  assign commit_ptr_d = flush_i ? '0 : commit_ptr_q + trans_id_t'(num_commit);
  assign issue_ptr_d  = flush_i ? '0 : issue_ptr_q + trans_id_t'(issue_en);

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      issued_q     <= '0;
      done_q       <= '0;
      exv_q        <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      issued_q     <= issued_d;
      done_q       <= done_d;
      exv_q        <= exv_d;
      issue_ptr_q  <= issue_ptr_d;
      commit_ptr_q <= commit_ptr_d;
      cnt_q        <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin : payload_regs
    mem_q <= mem_d;
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  // circular pointers wrap only on a power of two depth
  initial begin
    assert (`SB_NR_ENTRIES == 2 ** IDX_W)
      else $fatal(1, "queue depth is not a power of two");
  end

  // commit stage may only retire finished entries
  for (genvar k = 0; k < `SB_NR_COMMIT; k++) begin : gen_commit_chk
    commit_ack_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      commit_ack_i[k] |-> commit_instr_o[k].valid)
      else $error("commit ack on port %0d without a valid entry", k);
  end

  // issue stage acks only an offered instruction
  issue_ack_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> issue_instr_valid_o)
    else $error("issue ack without issue valid");

endmodule

`default_nettype wire

// File: logic/sb_clobber_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_config.svh"

module sb_clobber_map (
  input  sb_instr_pkg::sb_entry_t [`SB_NR_ENTRIES-1:0] entries_i,
  input  logic [`SB_NR_ENTRIES-1:0]                    issued_i,
  output sb_port_pkg::clobber_vec_t                    rd_clobber_o
);
  import sb_instr_pkg::*;

  // ----------------------------------------------------------
  // pending writer per register
  // ----------------------------------------------------------
  // scan from the top so the lowest matching slot wins,
  // normally at most one issued entry targets a register
  always_comb begin : sel_clobber
    for (int r = 0; r < `SB_NR_REGS; r++) begin
      rd_clobber_o[r] = NONE;
      for (int i = `SB_NR_ENTRIES - 1; i >= 0; i--) begin
        if (issued_i[i] && (entries_i[i].rd == reg_addr_t'(r))) begin
          rd_clobber_o[r] = entries_i[i].fu;
        end
      end
    end

    // x0 is hardwired, nothing ever writes it
    rd_clobber_o[0] = NONE;
  end

endmodule

`default_nettype wire

// File: logic/sb_operand_fwd.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_config.svh"

module sb_operand_fwd (
  input  sb_instr_pkg::reg_addr_t                      rs1_i,
  input  sb_instr_pkg::reg_addr_t                      rs2_i,
  input  sb_port_pkg::wb_port_t                        wb_i,
  input  sb_instr_pkg::sb_entry_t [`SB_NR_ENTRIES-1:0] entries_i,
  input  logic [`SB_NR_ENTRIES-1:0]                    issued_i,
  output logic [`SB_XLEN-1:0]                          rs1_o,
  output logic                                         rs1_valid_o,
  output logic [`SB_XLEN-1:0]                          rs2_o,
  output logic                                         rs2_valid_o
);
  import sb_instr_pkg::*;

  // forwarding result for one source operand
  typedef struct packed {
    logic                valid;
    logic [`SB_XLEN-1:0] data;
  } fwd_t;

  fwd_t      rs1_fwd;
  fwd_t      rs2_fwd;
  reg_addr_t wb_rd;
  logic      wb_fwd_ok;

  // ----------------------------------------------------------
  // write-back port in flight
  // ----------------------------------------------------------
  // destination comes from the entry the beat is aimed at
  assign wb_rd = entries_i[wb_i.trans_id].rd;

  // a faulting result must not reach the operands
  assign wb_fwd_ok = wb_i.valid & ~wb_i.ex.valid;

  // ----------------------------------------------------------
  // source selection
  // ----------------------------------------------------------
  // fixed priority: wb port, then finished entries lowest slot first
  function automatic fwd_t select_src(reg_addr_t rs);
    fwd_t res;
    res = '0;

    // walk down so lower slots overwrite higher ones
    for (int i = `SB_NR_ENTRIES - 1; i >= 0; i--) begin
      if (issued_i[i] && entries_i[i].valid && (entries_i[i].rd == rs)) begin
        res.valid = 1'b1;
        res.data  = entries_i[i].result;
      end
    end

    // the wb beat is newer than anything stored
    if (wb_fwd_ok && (wb_rd == rs)) begin
      res.valid = 1'b1;
      res.data  = wb_i.data;
    end

    // x0 reads from the register file as zero
    if (rs == '0) begin
      res.valid = 1'b0;
    end
    return res;
  endfunction

  always_comb begin : fwd_rs1
    rs1_fwd = select_src(rs1_i);
  end

  always_comb begin : fwd_rs2
    rs2_fwd = select_src(rs2_i);
  end

  assign rs1_o       = rs1_fwd.data;
  assign rs1_valid_o = rs1_fwd.valid;
  assign rs2_o       = rs2_fwd.data;
  assign rs2_valid_o = rs2_fwd.valid;

endmodule

`default_nettype wire

// File: logic/scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_config.svh"

module scoreboard (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        flush_i,
  input  logic                                        flush_unissued_i,
  input  logic                                        unresolved_branch_i,
  output logic                                        sb_full_o,
  // decoder side
  input  sb_instr_pkg::sb_entry_t                     decoded_instr_i,
  input  logic                                        decoded_instr_valid_i,
  output logic                                        decoded_instr_ack_o,
  // issue stage
  output sb_instr_pkg::sb_entry_t                     issue_instr_o,
  output logic                                        issue_instr_valid_o,
  input  logic                                        issue_ack_i,
  output sb_port_pkg::clobber_vec_t                   rd_clobber_o,
  // operand read
  input  sb_instr_pkg::reg_addr_t                     rs1_i,
  output logic [`SB_XLEN-1:0]                         rs1_o,
  output logic                                        rs1_valid_o,
  input  sb_instr_pkg::reg_addr_t                     rs2_i,
  output logic [`SB_XLEN-1:0]                         rs2_o,
  output logic                                        rs2_valid_o,
  // functional units and commit
  input  sb_port_pkg::wb_port_t                       wb_i,
  output sb_instr_pkg::sb_entry_t [`SB_NR_COMMIT-1:0] commit_instr_o,
  input  logic [`SB_NR_COMMIT-1:0]                    commit_ack_i
);
  import sb_instr_pkg::*;

  sb_entry_t [`SB_NR_ENTRIES-1:0] entries;
  logic [`SB_NR_ENTRIES-1:0]      issued;
  trans_id_t                      issue_trans_id;

  // ----------------------------------------------------------
  // issue record, id taken from the issue pointer
  // ----------------------------------------------------------
  always_comb begin : issue_record
    issue_instr_o          = decoded_instr_i;
    issue_instr_o.trans_id = issue_trans_id;
  end

  sb_issue_queue u_queue (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .flush_unissued_i      (flush_unissued_i),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .issue_ack_i           (issue_ack_i),
    .unresolved_branch_i   (unresolved_branch_i),
    .wb_i                  (wb_i),
    .commit_ack_i          (commit_ack_i),
    .issue_instr_valid_o   (issue_instr_valid_o),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .issue_trans_id_o      (issue_trans_id),
    .sb_full_o             (sb_full_o),
    .commit_instr_o        (commit_instr_o),
    .entries_o             (entries),
    .issued_o              (issued)
  );

  // registered view, so clobbers show one cycle after the store
  sb_clobber_map u_clobber (
    .entries_i    (entries),
    .issued_i     (issued),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_operand_fwd u_fwd (
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .wb_i        (wb_i),
    .entries_i   (entries),
    .issued_i    (issued),
    .rs1_o       (rs1_o),
    .rs1_valid_o (rs1_valid_o),
    .rs2_o       (rs2_o),
    .rs2_valid_o (rs2_valid_o)
  );

endmodule

`default_nettype wire

// File: bench/tb_scoreboard_tests.svh
`ifndef TB_SCOREBOARD_TESTS_SVH
`define TB_SCOREBOARD_TESTS_SVH

// ----------------------------------------------------------
// stimulus helpers
// ----------------------------------------------------------
function automatic logic [`SB_XLEN-1:0] rand_word();
  return {$random(seed), $random(seed)};
endfunction

// never x0
function automatic reg_addr_t rand_reg();
  return reg_addr_t'($random(seed)) | reg_addr_t'(1);
endfunction

// finished entry as commit should present it
function automatic sb_entry_t make_entry(trans_id_t id, fu_t fu, reg_addr_t rd,
                                         logic [`SB_XLEN-1:0] res, exception_t ex);
  sb_entry_t e;
  e          = '0;
  e.trans_id = id;
  e.fu       = fu;
  e.rd       = rd;
  e.result   = res;
  e.valid    = 1'b1;
  e.ex       = ex;
  return e;
endfunction

function automatic wb_port_t make_beat(trans_id_t id, logic [`SB_XLEN-1:0] data,
                                       exception_t ex);
  wb_port_t beat;
  beat.valid    = 1'b1;
  beat.trans_id = id;
  beat.data     = data;
  beat.ex       = ex;
  return beat;
endfunction

// offer one instruction, check its record and id, then ack it
task automatic issue_instr(input string name, input fu_t fu, input reg_addr_t rd,
                           input trans_id_t exp_id);
  sb_entry_t rec;
  int        cycles;
  rec          = '0;
  rec.fu       = fu;
  rec.rd       = rd;
  // junk id, the scoreboard must replace it
  rec.trans_id = ~exp_id;
  cycles       = 0;
  @(posedge clk_i);
  decoded_instr_i       <= rec;
  decoded_instr_valid_i <= 1'b1;
  do begin
    @(negedge clk_i);
    cycles++;
    if (cycles > TIMEOUT) begin
      $display("%s: issue valid never came up", name);
      abort_run();
    end
  end while (!issue_instr_valid_o);
  rec.trans_id = exp_id;
  check_entry(name, rec, issue_instr_o);
  @(posedge clk_i);
  issue_ack_i <= 1'b1;
  // decoder sees the handshake while the queue has room
  @(negedge clk_i);
  check_bit({name, " decoder ack"}, 1'b1, decoded_instr_ack_o);
  @(posedge clk_i);
  decoded_instr_valid_i <= 1'b0;
  issue_ack_i           <= 1'b0;
endtask

task automatic write_back(input trans_id_t id, input logic [`SB_XLEN-1:0] data);
  @(posedge clk_i);
  wb_i <= make_beat(id, data, '0);
  @(posedge clk_i);
  wb_i <= '0;
endtask

// wait until the acked ports hold finished entries, then retire them
task automatic commit(input logic [`SB_NR_COMMIT-1:0] ack);
  int cycles;
  cycles = 0;
  @(negedge clk_i);
  while (!commit_instr_o[0].valid || (ack[1] && !commit_instr_o[1].valid)) begin
    @(negedge clk_i);
    cycles++;
    if (cycles > TIMEOUT) begin
      $display("commit ports never showed finished entries");
      abort_run();
    end
  end
  @(posedge clk_i);
  commit_ack_i <= ack;
  @(posedge clk_i);
  commit_ack_i <= '0;
endtask

// flush takes effect at the second edge
task automatic do_flush();
  @(posedge clk_i);
  flush_i <= 1'b1;
  @(posedge clk_i);
  flush_i <= 1'b0;
endtask

// ----------------------------------------------------------
// directed tests
// ----------------------------------------------------------
task automatic test_issue_ids();
  for (int i = 0; i < `SB_NR_ENTRIES - 1; i++) begin
    issue_instr("issue_ids", ALU, reg_addr_t'(i + 1), trans_id_t'(i));
  end
  // decoder keeps offering, full alone must drop issue valid
  @(posedge clk_i);
  decoded_instr_valid_i <= 1'b1;
  @(negedge clk_i);
  check_bit("issue_ids full", 1'b1, sb_full_o);
  check_bit("issue_ids valid while full", 1'b0, issue_instr_valid_o);
  do_flush();
  @(negedge clk_i);
  check_bit("issue_ids full after flush", 1'b0, sb_full_o);
  @(posedge clk_i);
  unresolved_branch_i <= 1'b1;
  @(negedge clk_i);
  check_bit("issue_ids branch stall", 1'b0, issue_instr_valid_o);
  // handshake completes but the unissued flush drops the store
  @(posedge clk_i);
  unresolved_branch_i <= 1'b0;
  issue_ack_i         <= 1'b1;
  flush_unissued_i    <= 1'b1;
  @(negedge clk_i);
  check_bit("issue_ids valid after branch", 1'b1, issue_instr_valid_o);
  @(posedge clk_i);
  decoded_instr_valid_i <= 1'b0;
  issue_ack_i           <= 1'b0;
  flush_unissued_i      <= 1'b0;
  issue_instr("issue_ids after unissued flush", ALU, 5'd1, 3'd0);
endtask

task automatic test_clobber();
  issue_instr("clobber", ALU, 5'd5, 3'd0);
  @(negedge clk_i);
  for (int r = 0; r < `SB_NR_REGS; r++) begin
    check_fu("clobber map", (r == 5) ? ALU : NONE, rd_clobber_o[r]);
  end
  issue_instr("clobber x0", LOAD, 5'd0, 3'd1);
  @(negedge clk_i);
  check_fu("clobber x0", NONE, rd_clobber_o[0]);
  write_back(3'd0, rand_word());
  write_back(3'd1, rand_word());
  commit(2'b11);
  @(negedge clk_i);
  check_fu("clobber after commit", NONE, rd_clobber_o[5]);
endtask

task automatic test_wb_commit();
  reg_addr_t           rd [3];
  logic [`SB_XLEN-1:0] res [3];
  fu_t                 fu [3];
  fu = '{ALU, MULT, CTRL_FLOW};
  for (int i = 0; i < 3; i++) begin
    rd[i]  = rand_reg();
    res[i] = rand_word();
    issue_instr("wb_commit", fu[i], rd[i], trans_id_t'(i));
  end
  // results come back out of order
  write_back(3'd1, res[1]);
  @(negedge clk_i);
  check_entry("wb_commit port1", make_entry(3'd1, fu[1], rd[1], res[1], '0),
              commit_instr_o[1]);
  check_bit("wb_commit port0 pending", 1'b0, commit_instr_o[0].valid);
  write_back(3'd0, res[0]);
  write_back(3'd2, res[2]);
  @(negedge clk_i);
  check_entry("wb_commit port0", make_entry(3'd0, fu[0], rd[0], res[0], '0),
              commit_instr_o[0]);
  commit(2'b11);
  @(negedge clk_i);
  check_entry("wb_commit after dual ack", make_entry(3'd2, fu[2], rd[2], res[2], '0),
              commit_instr_o[0]);
  check_bit("wb_commit port1 empty", 1'b0, commit_instr_o[1].valid);
  commit(2'b01);
endtask

task automatic test_forwarding();
  logic [`SB_XLEN-1:0] data;
  logic [`SB_XLEN-1:0] data2;
  data  = rand_word();
  data2 = rand_word();
  issue_instr("forward", ALU, 5'd7, 3'd0);
  issue_instr("forward", MULT, 5'd9, 3'd1);
  issue_instr("forward", CSR, 5'd0, 3'd2);
  @(posedge clk_i);
  rs1_i <= 5'd7;
  rs2_i <= 5'd9;
  @(negedge clk_i);
  check_bit("forward rs1 unfinished", 1'b0, rs1_valid_o);
  check_bit("forward rs2 unfinished", 1'b0, rs2_valid_o);
  @(posedge clk_i);
  wb_i <= make_beat(3'd0, data, '0);
  @(negedge clk_i);
  check_bit("forward rs1 from wb", 1'b1, rs1_valid_o);
  check_data("forward rs1 from wb", data, rs1_o);
  // second source taken from the port
  @(posedge clk_i);
  wb_i <= make_beat(3'd1, data2, '0);
  @(negedge clk_i);
  check_bit("forward rs2 from wb", 1'b1, rs2_valid_o);
  check_data("forward rs2 from wb", data2, rs2_o);
  // beat to the x0 entry while slot 0 is now finished
  @(posedge clk_i);
  wb_i  <= make_beat(3'd2, rand_word(), '0);
  rs2_i <= 5'd0;
  @(negedge clk_i);
  check_bit("forward rs1 from entry", 1'b1, rs1_valid_o);
  check_data("forward rs1 from entry", data, rs1_o);
  check_bit("forward x0", 1'b0, rs2_valid_o);
  @(posedge clk_i);
  wb_i <= '0;
endtask

task automatic test_exception();
  exception_t          ex;
  logic [`SB_XLEN-1:0] data;
  ex.cause = rand_word();
  ex.tval  = rand_word();
  ex.valid = 1'b1;
  data     = rand_word();
  issue_instr("exception", LOAD, 5'd11, 3'd0);
  @(posedge clk_i);
  rs1_i <= 5'd11;
  wb_i  <= make_beat(3'd0, data, ex);
  @(negedge clk_i);
  check_bit("exception not forwarded", 1'b0, rs1_valid_o);
  @(posedge clk_i);
  wb_i <= '0;
  @(negedge clk_i);
  check_entry("exception commit", make_entry(3'd0, LOAD, 5'd11, data, ex),
              commit_instr_o[0]);
  commit(2'b01);
endtask

task automatic test_flush();
  for (int i = 0; i < `SB_NR_ENTRIES - 1; i++) begin
    issue_instr("flush fill", STORE, rand_reg(), trans_id_t'(i));
  end
  write_back(3'd0, rand_word());
  @(negedge clk_i);
  check_bit("flush full before", 1'b1, sb_full_o);
  check_bit("flush commit before", 1'b1, commit_instr_o[0].valid);
  do_flush();
  @(negedge clk_i);
  check_idle("flush idle");
  issue_instr("flush restart", ALU, 5'd3, 3'd0);
endtask

`endif

// File: bench/tb_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

`include "sb_config.svh"

module tb_scoreboard;
  import sb_instr_pkg::*;
  import sb_port_pkg::*;

  // longest any single wait may take, in cycles
  localparam int TIMEOUT = 40;

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  logic                          flush_i;
  logic                          flush_unissued_i;
  logic                          unresolved_branch_i;
  logic                          sb_full_o;
  sb_entry_t                     decoded_instr_i;
  logic                          decoded_instr_valid_i;
  logic                          decoded_instr_ack_o;
  sb_entry_t                     issue_instr_o;
  logic                          issue_instr_valid_o;
  logic                          issue_ack_i;
  clobber_vec_t                  rd_clobber_o;
  reg_addr_t                     rs1_i;
  logic [`SB_XLEN-1:0]           rs1_o;
  logic                          rs1_valid_o;
  reg_addr_t                     rs2_i;
  logic [`SB_XLEN-1:0]           rs2_o;
  logic                          rs2_valid_o;
  wb_port_t                      wb_i;
  sb_entry_t [`SB_NR_COMMIT-1:0] commit_instr_o;
  logic [`SB_NR_COMMIT-1:0]      commit_ack_i;

  int     error_count = 0;
  integer seed        = 32'hdc3d6f86;

  // 8 ns clock
  always #4 clk_i = ~clk_i;

  scoreboard DUT (.*);

  // ----------------------------------------------------------
  // failure and compare tasks
  // ----------------------------------------------------------
  task automatic abort_run();
    error_count++;
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_entry(input string name, input sb_entry_t exp, input sb_entry_t act);
    if (act !== exp) begin
      $display("error %s: expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_fu(input string name, input fu_t exp, input fu_t act);
    if (act !== exp) begin
      $display("error %s: expected %s actual %s", name, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input logic [`SB_XLEN-1:0] exp,
                            input logic [`SB_XLEN-1:0] act);
    if (act !== exp) begin
      $display("error %s: expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s: expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // empty queue: not full, nothing to commit, no register clobbered
  task automatic check_idle(input string name);
    check_bit(name, 1'b0, sb_full_o);
    for (int k = 0; k < `SB_NR_COMMIT; k++) begin
      check_bit(name, 1'b0, commit_instr_o[k].valid);
    end
    for (int r = 0; r < `SB_NR_REGS; r++) begin
      check_fu(name, NONE, rd_clobber_o[r]);
    end
  endtask

  `include "tb_scoreboard_tests.svh"

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    rst_ni                <= 1'b0;
    flush_i               <= 1'b0;
    flush_unissued_i      <= 1'b0;
    unresolved_branch_i   <= 1'b0;
    decoded_instr_i       <= '0;
    decoded_instr_valid_i <= 1'b0;
    issue_ack_i           <= 1'b0;
    rs1_i                 <= '0;
    rs2_i                 <= '0;
    wb_i                  <= '0;
    commit_ack_i          <= '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_idle("reset");

    // every test starts from an empty queue
    test_issue_ids();
    do_flush();
    test_clobber();
    do_flush();
    test_wb_commit();
    do_flush();
    test_forwarding();
    do_flush();
    test_exception();
    do_flush();
    test_flush();

    @(negedge clk_i);
    if (error_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
+incdir+bench
common/sb_instr_pkg.sv
common/sb_port_pkg.sv
issue_queue/sb_issue_queue.sv
logic/sb_clobber_map.sv
logic/sb_operand_fwd.sv
logic/scoreboard.sv
bench/tb_scoreboard.sv
